// ==== include/icache_defines.svh ====
// Width and reset constants for the instruction cache, included by the package, RTL and testbench
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// Fetch byte address width
`define ICACHE_ADDR_BITS 32

// Instruction word width
`define ICACHE_DATA_BITS 32

// Set index width for address bits 3:2
`define ICACHE_SET_BITS 2

// Width of the hit and miss counters
`define ICACHE_CNT_BITS 20

// Nonzero reset value of the replacement LFSR
`define LFSR_SEED 16'hACE1

`endif

// ==== source/icachePkg.sv ====
// Shared cache types, imported by the request, lookup and statistics blocks
`default_nettype none

`include "icache_defines.svh"

package icachePkg;

    typedef logic [`ICACHE_ADDR_BITS-1:0] addrT;   // Fetch byte address

    // Tag is everything above the set index and the byte offset
    typedef logic [`ICACHE_ADDR_BITS-`ICACHE_SET_BITS-3:0] tagT;

    typedef logic [`ICACHE_SET_BITS-1:0] setT;     // Address bits 3:2
    typedef logic [`ICACHE_DATA_BITS-1:0] wordT;   // One cache line
    typedef logic [`ICACHE_CNT_BITS-1:0] countT;   // Statistics counter

    // Lookup stage FSM
    typedef enum logic [1:0] {
        idleLookup,   // Compare both ways, answer hits
        missWait,     // Memory read outstanding
        fillRespond   // Write the line, response on the outputs
    } lookupStateT;

endpackage

`default_nettype wire

// ==== source/fetchIf.sv ====
// Decoded fetch request passed from the request stage to the lookup stage
`timescale 1ns/100ps
`default_nettype none

interface fetchIf;
    import icachePkg::*;

    logic valid;    // Entry present in the request stage
    setT  setIdx;   // Address bits 3:2
    tagT  tag;      // Address bits 31:4
    logic stall;    // Lookup busy with a miss

    // Request stage side
    modport source (
        output valid,
        output setIdx,
        output tag,
        input  stall
    );

    // Lookup stage side
    modport sink (
        input  valid,
        input  setIdx,
        input  tag,
        output stall
    );

endinterface

`default_nettype wire

// ==== source/fetchRequest.sv ====
// Request stage of the fetch pipeline; registers one fetch and holds it while lookup stalls
`timescale 1ns/100ps
`default_nettype none

module fetchRequest (
    input  wire logic            CLK,
    input  wire logic            RESET,
    input  wire logic            fetchValid,
    input  wire icachePkg::addrT fetchAddr,
    output logic                 fetchReady,
    fetchIf.source               req
);
    import icachePkg::*;

    logic readyEn;     // Keeps fetchReady low until the first cycle after reset
    logic entryValid;
    setT  entrySet;
    tagT  entryTag;

    // Take a new request when empty or when the held one moves on
    assign fetchReady = readyEn & (~entryValid | ~req.stall);

    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            readyEn    <= 1'b0;
            entryValid <= 1'b0;
        end else begin
            readyEn <= 1'b1;
            if (fetchReady) begin
                entryValid <= fetchValid;   // Load the next request or drain
            end
        end
    end

    // Split the byte address and drop the low two bits
    always_ff @(posedge CLK) begin
        if (fetchReady && fetchValid) begin
            entrySet <= fetchAddr[2 +: $bits(setT)];
            entryTag <= fetchAddr[$bits(addrT)-1 -: $bits(tagT)];
        end
    end

    assign req.valid  = entryValid;
    assign req.setIdx = entrySet;
    assign req.tag    = entryTag;

endmodule

`default_nettype wire

// ==== source/cacheLookup.sv ====
// Lookup stage; two-way tag compare, miss handling with memory fill, and fetch responses
`timescale 1ns/100ps
`default_nettype none

`include "icache_defines.svh"

module cacheLookup (
    input  wire logic            CLK,
    input  wire logic            RESET,
    fetchIf.sink                 req,
    output logic                 respValid,
    output logic                 respHit,
    output icachePkg::wordT      respData,
    output logic                 memReq,
    output icachePkg::addrT      memAddr,
    input  wire logic            memValid,
    input  wire icachePkg::wordT memData,
    output logic                 hitPulse,
    output logic                 missPulse
);
    import icachePkg::*;

    localparam int numSets = 1 << $bits(setT);

    lookupStateT state;

    logic lookValid;   // Request registered for compare
    setT  lookSet;
    tagT  lookTag;

    logic wayValid [2][numSets];
    tagT  wayTag   [2][numSets];
    wordT wayData  [2][numSets];

    logic [15:0] lfsr;   // Victim choice when both ways are full

    logic hit0;
    logic hit1;
    logic hitAny;
    logic lookupNow;
    wordT hitData;
    setT  fillSet;
    tagT  fillTag;
    logic fillWay;

    assign req.stall = (state != idleLookup);
    assign lookupNow = lookValid && (state == idleLookup);

    assign hit0    = wayValid[0][lookSet] && (wayTag[0][lookSet] == lookTag);
    assign hit1    = wayValid[1][lookSet] && (wayTag[1][lookSet] == lookTag);
    assign hitAny  = hit0 | hit1;
    assign hitData = hit0 ? wayData[0][lookSet] : wayData[1][lookSet];

    // One pulse per resolved lookup
    assign hitPulse  = lookupNow & hitAny;
    assign missPulse = lookupNow & ~hitAny;

    // The outstanding miss address also names the line to fill
    assign fillSet = memAddr[2 +: $bits(setT)];
    assign fillTag = memAddr[$bits(addrT)-1 -: $bits(tagT)];

    // Invalid ways fill first, starting with way 0
    always_comb begin
        if (!wayValid[0][fillSet]) begin
            fillWay = 1'b0;
        end else if (!wayValid[1][fillSet]) begin
            fillWay = 1'b1;
        end else begin
            fillWay = lfsr[0];
        end
    end

    // Pipeline register refilled only while the FSM is idle
    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            lookValid <= 1'b0;
        end else if (state == idleLookup) begin
            lookValid <= req.valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (state == idleLookup && req.valid) begin
            lookSet <= req.setIdx;
            lookTag <= req.tag;
        end
    end

    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            state     <= idleLookup;
            respValid <= 1'b0;
            respHit   <= 1'b0;
            memReq    <= 1'b0;
            lfsr      <= `LFSR_SEED;
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < numSets; s++) begin
                    wayValid[w][s] <= 1'b0;
                end
            end
        end else begin
            respValid <= 1'b0;   // Single-cycle response
            case (state)
                idleLookup: begin
                    if (lookValid) begin
                        if (hitAny) begin
                            respValid <= 1'b1;
                            respHit   <= 1'b1;
                        end else begin
                            respHit <= 1'b0;
                            memReq  <= 1'b1;
                            state   <= missWait;
                        end
                    end
                end
                missWait: begin
                    if (memValid) begin
                        memReq    <= 1'b0;
                        respValid <= 1'b1;   // Shows up during fillRespond
                        respHit   <= 1'b0;
                        state     <= fillRespond;
                    end
                end
                fillRespond: begin
                    wayValid[fillWay][fillSet] <= 1'b1;
                    lfsr  <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
                    state <= idleLookup;
                end
                default: begin
                    state <= idleLookup;
                end
            endcase
        end
    end

    // Payload path
    always_ff @(posedge CLK) begin
        if (lookupNow && hitAny) begin
            respData <= hitData;
        end
        if (lookupNow && !hitAny) begin
            memAddr <= {lookTag, lookSet, 2'b00};   // Word aligned
        end
        if (state == missWait && memValid) begin
            respData <= memData;
        end
        if (state == fillRespond) begin
            wayTag[fillWay][fillSet]  <= fillTag;
            wayData[fillWay][fillSet] <= respData;   // Still holds the memory word
        end
    end

endmodule

`default_nettype wire

// ==== source/statsApb.sv ====
// APB slave exposing the cache hit and miss counters; any write clears both
`timescale 1ns/100ps
`default_nettype none

module statsApb (
    input  wire logic        CLK,
    input  wire logic        RESET,
    input  wire logic        hitPulse,
    input  wire logic        missPulse,
    input  wire logic        PSEL,
    input  wire logic        PENABLE,
    input  wire logic        PWRITE,
    input  wire logic [3:0]  PADDR,
    input  wire logic [31:0] PWDATA,
    output logic      [31:0] PRDATA,
    output logic             PREADY
);
    import icachePkg::*;

    countT hitCount;
    countT missCount;
    logic  apbWrite;

    // Counters stick at all ones
    function automatic countT bumpCount(countT value, logic inc);
        if (inc && value != '1) begin
            return value + 1'b1;
        end
        return value;
    endfunction

    assign apbWrite = PSEL & PENABLE & PWRITE;   // Write in the access phase
    assign PREADY   = 1'b1;                      // No wait states

    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            hitCount  <= '0;
            missCount <= '0;
        end else if (apbWrite) begin
            hitCount  <= '0;   // Clear wins over a same-cycle count
            missCount <= '0;
        end else begin
            hitCount  <= bumpCount(hitCount, hitPulse);
            missCount <= bumpCount(missCount, missPulse);
        end
    end

    // Zero padded read mux
    always_comb begin
        PRDATA = '0;
        case (PADDR)
            4'h0: PRDATA = {{($bits(PRDATA) - $bits(countT)){1'b0}}, hitCount};
            4'h4: PRDATA = {{($bits(PRDATA) - $bits(countT)){1'b0}}, missCount};
            default: PRDATA = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/icacheTop.sv ====
// Instruction cache top level; request stage, lookup stage and APB statistics on plain ports
`timescale 1ns/100ps
`default_nettype none

module icacheTop (
    input  wire logic            CLK,
    input  wire logic            RESET,
    // Fetch request
    input  wire logic            fetchValid,
    input  wire icachePkg::addrT fetchAddr,
    output wire logic            fetchReady,
    // Fetch response
    output wire logic            respValid,
    output wire icachePkg::wordT respData,
    output wire logic            respHit,
    // External memory
    output wire logic            memReq,
    output wire icachePkg::addrT memAddr,
    input  wire logic            memValid,
    input  wire icachePkg::wordT memData,
    // APB statistics
    input  wire logic            PSEL,
    input  wire logic            PENABLE,
    input  wire logic            PWRITE,
    input  wire logic [3:0]      PADDR,
    input  wire logic [31:0]     PWDATA,
    output wire logic [31:0]     PRDATA,
    output wire logic            PREADY
);

    wire hitPulse;
    wire missPulse;

    fetchIf reqLink ();

    fetchRequest uRequest (
        .CLK        (CLK),
        .RESET      (RESET),
        .fetchValid (fetchValid),
        .fetchAddr  (fetchAddr),
        .fetchReady (fetchReady),
        .req        (reqLink.source)
    );

    cacheLookup uLookup (
        .CLK       (CLK),
        .RESET     (RESET),
        .req       (reqLink.sink),
        .respValid (respValid),
        .respHit   (respHit),
        .respData  (respData),
        .memReq    (memReq),
        .memAddr   (memAddr),
        .memValid  (memValid),
        .memData   (memData),
        .hitPulse  (hitPulse),
        .missPulse (missPulse)
    );

    statsApb uStats (
        .CLK       (CLK),
        .RESET     (RESET),
        .hitPulse  (hitPulse),
        .missPulse (missPulse),
        .PSEL      (PSEL),
        .PENABLE   (PENABLE),
        .PWRITE    (PWRITE),
        .PADDR     (PADDR),
        .PWDATA    (PWDATA),
        .PRDATA    (PRDATA),
        .PREADY    (PREADY)
    );

endmodule

`default_nettype wire

// ==== tests/clockGen.sv ====
// Testbench clock and reset source; 40 ns clock with reset held high for the first 5 cycles
`timescale 1ns/100ps
`default_nettype none

module clockGen (
    output logic CLK,
    output logic RESET
);

    initial begin
        CLK   = 1'b0;
        RESET = 1'b1;
        forever #20 CLK = ~CLK;   // 40 ns period
    end

    initial begin
        repeat (5) @(posedge CLK);
        RESET <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== tests/icacheTb.sv ====
// Random fetch testbench for icacheTop; memory responder, residency model and APB counter checks
`timescale 1ns/100ps
`default_nettype none

module icacheTb;

    localparam int totalRequests = 300 + 4 + 7 + 40;
    localparam int cycleLimit    = 20 * totalRequests + 200;

    logic        CLK;
    logic        RESET;
    logic        fetchValid = 1'b0;
    logic [31:0] fetchAddr  = 32'h0;
    logic        fetchReady;
    logic        respValid;
    logic [31:0] respData;
    logic        respHit;
    logic        memReq;
    logic [31:0] memAddr;
    logic        memValid   = 1'b0;
    logic [31:0] memData    = 32'h0;
    logic        PSEL       = 1'b0;
    logic        PENABLE    = 1'b0;
    logic        PWRITE     = 1'b0;
    logic [3:0]  PADDR      = 4'h0;
    logic [31:0] PWDATA     = 32'h0;
    logic [31:0] PRDATA;
    logic        PREADY;

    integer seed = 32'h96eb3ce8;
    int     errorCount = 0;
    int     testsPassed = 0;
    int     testsFailed = 0;
    int     cycles = 0;
    int     hitSeen = 0;
    int     missSeen = 0;
    int     respCount = 0;  // Every respValid pulse, matched or not
    int     status [17];    // 0 absent, 1 resident, 2 uncertain
    int     validCnt [4];   // Filled ways per set
    int     expIdx [$];     // Outstanding requests, oldest first
    time    expTime [$];    // Acceptance edge of each
    bit     hitLog [$];
    time    memValidT = 0;
    logic   memReqPrev = 1'b0;
    bit     checkTiming = 1'b0;
    bit     streamOn = 1'b0;
    bit     busy = 1'b0;
    int     waitLeft = 0;

    clockGen clocks (.CLK(CLK), .RESET(RESET));

    icacheTop dut (
        .CLK(CLK), .RESET(RESET),
        .fetchValid(fetchValid), .fetchAddr(fetchAddr), .fetchReady(fetchReady),
        .respValid(respValid), .respData(respData), .respHit(respHit),
        .memReq(memReq), .memAddr(memAddr), .memValid(memValid), .memData(memData),
        .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE), .PADDR(PADDR),
        .PWDATA(PWDATA), .PRDATA(PRDATA), .PREADY(PREADY)
    );

    // Address pool; 0..11 cover sets 0-2, 12/13 are cold, 14..16 share set 3
    function automatic logic [31:0] poolAddr(int i);
        logic [27:0] tagv;
        logic [1:0]  s;
        if (i < 12) begin
            tagv = 28'h0123400 + 28'(i / 3);
            s    = 2'(i % 3);
        end else if (i < 14) begin
            tagv = 28'h0777000 + 28'(i - 12);
            s    = 2'(i - 12);
        end else begin
            tagv = 28'h0888000 + 28'(i - 14);
            s    = 2'd3;
        end
        return {tagv, s, 2'b00};
    endfunction

    function automatic int setOf(int i);
        logic [31:0] a;
        a = poolAddr(i);
        return int'(a[3:2]);
    endfunction

    function automatic logic [31:0] memWord(logic [31:0] a);
        return a ^ 32'h5A5A0000 ^ {a[28:0], a[31:29]};
    endfunction

    // Invalid ways fill first; a full set loses an unknown way
    task automatic updateModel(int idx, bit hit);
        int s;
        int resident;
        s = setOf(idx);
        resident = 0;
        if (hit) begin
            status[idx] = 1;
        end else begin
            if (validCnt[s] < 2) begin
                validCnt[s]++;
            end else begin
                for (int j = 0; j < 17; j++) begin
                    if (setOf(j) == s && status[j] == 1) status[j] = 2;
                end
            end
            status[idx] = 1;
        end
        for (int j = 0; j < 17; j++) begin
            if (setOf(j) == s && status[j] == 1) resident++;
        end
        if (resident >= 2) begin   // Both ways known
            for (int j = 0; j < 17; j++) begin
                if (setOf(j) == s && status[j] == 2) status[j] = 0;
            end
        end
    endtask

    // Memory responder answering after 1 to 6 cycles
    always @(posedge CLK) begin
        memValid <= 1'b0;
        if (!busy && memReq && !memValid) begin
            busy     <= 1'b1;
            waitLeft <= 1 + int'($unsigned($random(seed)) % 6);
        end else if (busy) begin
            if (waitLeft <= 1) begin
                memValid <= 1'b1;
                memData  <= memWord(memAddr);
                busy     <= 1'b0;
            end else begin
                waitLeft <= waitLeft - 1;
            end
        end
    end

    // Output monitor sampling at the falling edge
    always @(negedge CLK) begin
        int  idx;
        time t;
        bit  modelHit;
        if (!RESET) begin
            if (respValid) begin
                respCount++;
                assert (expIdx.size() != 0) else begin
                    $display("Response arrived with no request outstanding at %0t", $time);
                    errorCount++;
                end
                if (expIdx.size() != 0) begin
                    idx = expIdx.pop_front();
                    t   = expTime.pop_front();
                    assert (respData == memWord(poolAddr(idx))) else begin
                        $display("FAIL %0t: data %h for address %h", $time, respData,
                                 poolAddr(idx));
                        errorCount++;
                    end
                    modelHit = (status[idx] == 2) ? respHit : (status[idx] == 1);
                    assert (respHit == modelHit) else begin
                        $display("FAIL %0t: respHit %b, model %b, address %h", $time,
                                 respHit, modelHit, poolAddr(idx));
                        errorCount++;
                    end
                    if (respHit) begin
                        hitSeen++;
                        assert (!checkTiming || $time == t + 100) else begin
                            $display("FAIL %0t: hit not two cycles after accept", $time);
                            errorCount++;
                        end
                    end else begin
                        missSeen++;
                        assert ($time == memValidT + 40) else begin
                            $display("FAIL %0t: miss response not after memValid", $time);
                            errorCount++;
                        end
                    end
                    updateModel(idx, modelHit);
                    hitLog.push_back(respHit);
                end
            end
            if (memReq && !memReqPrev && expIdx.size() != 0) begin
                assert (memAddr == poolAddr(expIdx[0])) else begin
                    $display("FAIL %0t: memAddr %h, expected %h", $time, memAddr,
                             poolAddr(expIdx[0]));
                    errorCount++;
                end
                assert (!checkTiming || $time == expTime[0] + 100) else begin
                    $display("FAIL %0t: memReq not two cycles after accept", $time);
                    errorCount++;
                end
            end
            assert (!(streamOn && fetchValid && memReq && fetchReady)) else begin
                $display("FAIL %0t: fetchReady high during a pending miss", $time);
                errorCount++;
            end
            if (memValid) memValidT = $time;
            memReqPrev = memReq;
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles > cycleLimit) begin
            $display("Timeout: the run went past %0d cycles", cycleLimit);
            $display("Test FAILED");
            $finish;
        end
    end

    // Called right after a rising edge and returns at the accepting edge
    task automatic issue(int idx);
        fetchValid <= 1'b1;
        fetchAddr  <= poolAddr(idx);
        @(negedge CLK);
        while (!fetchReady) @(negedge CLK);
        @(posedge CLK);
        expIdx.push_back(idx);
        expTime.push_back($time);
    endtask

    task automatic finishRequests();
        fetchValid <= 1'b0;
        while (expIdx.size() != 0) @(posedge CLK);
        @(posedge CLK);
    endtask

    task automatic apbTransfer(logic wr, logic [3:0] addr, output logic [31:0] data);
        PSEL    <= 1'b1;
        PENABLE <= 1'b0;
        PWRITE  <= wr;
        PADDR   <= addr;
        PWDATA  <= 32'h0;
        @(posedge CLK);
        PENABLE <= 1'b1;
        @(negedge CLK);
        data = PRDATA;   // Access phase
        assert (PREADY) else begin
            $display("FAIL %0t: PREADY low", $time);
            errorCount++;
        end
        @(posedge CLK);
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
    endtask

    task automatic reportTest(string name, int errBefore);
        if (errorCount == errBefore) begin
            $display("%s: passed", name);
            testsPassed++;
        end else begin
            $display("%s: failed", name);
            testsFailed++;
        end
    endtask

    initial begin
        int          errBefore;
        int          base;
        logic [31:0] rd;
        for (int j = 0; j < 17; j++) status[j] = 0;
        for (int s = 0; s < 4; s++) validCnt[s] = 0;
        @(negedge RESET);
        @(posedge CLK);

        errBefore = errorCount;
        for (int n = 0; n < 300; n++) issue(int'($unsigned($random(seed)) % 12));
        finishRequests();
        reportTest("Data integrity", errBefore);

        errBefore = errorCount;
        checkTiming = 1'b1;
        base = hitLog.size();
        for (int k = 12; k < 14; k++) begin
            issue(k);
            finishRequests();
            issue(k);
            finishRequests();
        end
        checkTiming = 1'b0;
        assert (hitLog.size() == base + 4 && !hitLog[base] && hitLog[base + 1]
                && !hitLog[base + 2] && hitLog[base + 3]) else begin
            $display("FAIL %0t: cold miss then hit pattern wrong", $time);
            errorCount++;
        end
        reportTest("Cold misses then hits", errBefore);

        errBefore = errorCount;
        base = hitLog.size();
        issue(14);
        finishRequests();
        issue(15);
        finishRequests();
        issue(14);
        issue(15);
        finishRequests();
        issue(16);
        finishRequests();
        issue(14);
        finishRequests();
        assert (!hitLog[base] && !hitLog[base + 1] && hitLog[base + 2]
                && hitLog[base + 3] && !hitLog[base + 4]) else begin
            $display("FAIL %0t: two-way residency pattern wrong", $time);
            errorCount++;
        end
        if (hitLog[base + 5]) begin   // First tag kept so the second was evicted
            issue(15);
            finishRequests();
            assert (!hitLog[base + 6]) else begin
                $display("FAIL %0t: both old tags resident after third fill", $time);
                errorCount++;
            end
        end
        reportTest("Two-way residency", errBefore);

        errBefore = errorCount;
        base = respCount;
        streamOn = 1'b1;
        for (int n = 0; n < 40; n++) issue(int'($unsigned($random(seed)) % 17));
        streamOn = 1'b0;
        finishRequests();
        repeat (16) @(posedge CLK);   // Longer than any miss, so a stray pulse shows up
        assert (respCount == base + 40) else begin
            $display("FAIL %0t: %0d responses for 40 requests", $time, respCount - base);
            errorCount++;
        end
        reportTest("Back-pressure", errBefore);

        errBefore = errorCount;
        apbTransfer(1'b0, 4'h0, rd);
        assert (rd == 32'(hitSeen)) else begin
            $display("FAIL %0t: hit count %0d, expected %0d", $time, rd, hitSeen);
            errorCount++;
        end
        apbTransfer(1'b0, 4'h4, rd);
        assert (rd == 32'(missSeen)) else begin
            $display("FAIL %0t: miss count %0d, expected %0d", $time, rd, missSeen);
            errorCount++;
        end
        apbTransfer(1'b1, 4'h0, rd);
        apbTransfer(1'b0, 4'h0, rd);
        assert (rd == 32'h0) else begin
            $display("FAIL %0t: hit count %0d after clear", $time, rd);
            errorCount++;
        end
        apbTransfer(1'b0, 4'h4, rd);
        assert (rd == 32'h0) else begin
            $display("FAIL %0t: miss count %0d after clear", $time, rd);
            errorCount++;
        end
        reportTest("Statistics over APB", errBefore);

        $display("%0d tests, %0d passed, %0d failed, %0d errors", testsPassed + testsFailed,
                 testsPassed, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
source/icachePkg.sv
source/fetchIf.sv
source/fetchRequest.sv
source/cacheLookup.sv
source/statsApb.sv
source/icacheTop.sv
tests/clockGen.sv
tests/icacheTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator and run the instruction cache testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module icacheTb -f flist.f -o simIcache

out=$(./obj_dir/simIcache)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
else
    exit 1
fi
